// File: stream_pkg.sv
// ------------------------------------------------
// stream types
// shared beat, header and sample formats of the
// sample stream, plus FIFO depth and the limits
// used when a scaled sample saturates
// ------------------------------------------------
package stream_pkg;

   // store depth, fixed by the 5-bit shift register address
   localparam int FIFO_DEPTH = 32;

   // limits of a 16-bit signed sample
   localparam logic signed [15:0] SAMPLE_MAX = 16'sh7fff;
   localparam logic signed [15:0] SAMPLE_MIN = -16'sh8000;

   // first word of a packet
   typedef struct packed
   {
      logic [3:0]  flags;
      // packet sequence number
      logic [11:0] seq;
      // payload length in words, header not counted
      logic [15:0] length;
   } pkt_header_t;

   // complex sample, I in the upper half
   typedef struct packed
   {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_sample_t;

   // one stream word seen either as header or as sample
   typedef union packed
   {
      pkt_header_t hdr;
      iq_sample_t  iq;
   } stream_word_u;

   // one beat on a stream link, 33 bits
   typedef struct packed
   {
      logic [31:0] data;
      // marks the final word of a packet
      logic        last;
   } stream_beat_t;

endpackage

// File: srl_shift_store.sv
`timescale 1ns/10ps
// ------------------------------------------------
// shift register store
// 32-deep addressable shift register, one lane per
// data bit, with a combinational read port
// ------------------------------------------------
module srl_shift_store #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             i_shift,
   input  logic [WIDTH-1:0] i_data,
   input  logic [4:0]       i_addr,
   output logic [WIDTH-1:0] o_data
);
   import stream_pkg::*;

   generate
      for (genvar b = 0; b < WIDTH; b++)
      begin : g_lane
         // position 0 holds the newest bit
         logic [FIFO_DEPTH-1:0] lane;

         always_ff @(posedge clk)
         begin
            if (i_shift)
            begin
               lane <= {lane[FIFO_DEPTH-2:0], i_data[b]};
            end
         end

         // read tap selected by the address
         assign o_data[b] = lane[i_addr];
      end
   endgenerate

endmodule

// File: axi_fifo_short.sv
`timescale 1ns/10ps
// ------------------------------------------------
// short stream FIFO
// 32-beat valid/ready FIFO built on a shift
// register store, with a registered output stage,
// synchronous clear and space/occupied counters
// ------------------------------------------------
module axi_fifo_short #(
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             i_clear,
   // input side
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             o_tready,
   // output side
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             i_tready,
   // diagnostics
   output logic [5:0]       o_space,
   output logic [5:0]       o_occupied
);
   import stream_pkg::*;

   logic [WIDTH-1:0] store_data;
   // address of the oldest word in the store
   logic [4:0]       rd_addr;
   logic             full;
   logic             empty;
   logic             write;
   logic             read_int;
   logic             read;
   logic             out_ready;

   // transfer into the store at the interface
   assign write    = i_tvalid & o_tready;
   // store to output register move
   assign read_int = ~empty & out_ready;
   // transfer out of the FIFO at the interface
   assign read     = o_tvalid & i_tready;

   // output register can load when empty or being drained
   assign out_ready = i_tready | ~o_tvalid;

   assign o_tready = ~full;

   srl_shift_store #(
      .WIDTH (WIDTH)
   ) u_store (
      .clk     (clk),
      .i_shift (write),
      .i_data  (i_tdata),
      .i_addr  (rd_addr),
      .o_data  (store_data)
   );

   // read address and flags
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         rd_addr <= '0;
         empty   <= 1'b1;
         full    <= 1'b0;
      end
      else if (read_int && !write)
      begin
         full <= 1'b0;
         if (rd_addr == 5'd0)
         begin
            empty <= 1'b1;
         end
         else
         begin
            rd_addr <= rd_addr - 5'd1;
         end
      end
      else if (write && !read_int)
      begin
         empty <= 1'b0;
         // first word lands at address 0, no move
         if (!empty)
         begin
            rd_addr <= rd_addr + 5'd1;
         end
         // store reaches 31 words, output register takes the 32nd
         if (!empty && rd_addr == 5'(FIFO_DEPTH - 3))
         begin
            full <= 1'b1;
         end
      end
   end

   // registered output stage
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_tvalid <= 1'b0;
      end
      else if (out_ready)
      begin
         o_tvalid <= ~empty;
         o_tdata  <= store_data;
      end
   end

   // counters move on interface transfers only
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_space    <= 6'(FIFO_DEPTH);
         o_occupied <= 6'd0;
      end
      else if (read && !write)
      begin
         o_space    <= o_space + 6'd1;
         o_occupied <= o_occupied - 6'd1;
      end
      else if (write && !read)
      begin
         o_space    <= o_space - 6'd1;
         o_occupied <= o_occupied + 6'd1;
      end
   end

endmodule

// File: iq_gain_stage.sv
`timescale 1ns/10ps
// ------------------------------------------------
// complex gain stage
// scales I and Q of every sample word by a gain
// latched at the packet header, with rounding and
// saturation; header words pass through unchanged
// ------------------------------------------------
module iq_gain_stage #(
   parameter int GAIN_FRAC_BITS = 14
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     i_clear,
   // unsigned gain, GAIN_FRAC_BITS fraction bits
   input  logic [15:0]              i_gain,
   // input side
   input  stream_pkg::stream_beat_t i_beat,
   input  logic                     i_valid,
   output logic                     o_ready,
   // output side
   output stream_pkg::stream_beat_t o_beat,
   output logic                     o_valid,
   input  logic                     i_ready
);
   import stream_pkg::*;

   // half an output lsb, added before the shift
   localparam int ROUND = 1 << (GAIN_FRAC_BITS - 1);

   logic         accept;
   // next accepted beat is a header
   logic         pkt_start;
   // gain held for the current packet
   logic [15:0]  pkt_gain;
   stream_word_u in_word;
   stream_word_u out_word;

   // scale one part, round half up, clamp to 16 bits
   function automatic logic signed [15:0] scale_part(
      input logic signed [15:0] value,
      input logic [15:0]        gain
   );
      logic signed [32:0] prod;
      logic signed [32:0] shifted;
      // gain widened with a zero sign bit so the product stays signed
      prod    = 33'(value) * 33'($signed({1'b0, gain}));
      shifted = (prod + 33'(ROUND)) >>> GAIN_FRAC_BITS;
      if (shifted > 33'(SAMPLE_MAX))
      begin
         scale_part = SAMPLE_MAX;
      end
      else if (shifted < 33'(SAMPLE_MIN))
      begin
         scale_part = SAMPLE_MIN;
      end
      else
      begin
         scale_part = shifted[15:0];
      end
   endfunction

   // holds one beat under a full stall
   assign o_ready = ~o_valid | i_ready;
   assign accept  = i_valid & o_ready;

   assign in_word = i_beat.data;

   // header as is, samples through the gain
   always_comb
   begin
      if (pkt_start)
      begin
         out_word.hdr = in_word.hdr;
      end
      else
      begin
         out_word.iq.i = scale_part(in_word.iq.i, pkt_gain);
         out_word.iq.q = scale_part(in_word.iq.q, pkt_gain);
      end
   end

   // packet boundary tracking
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         pkt_start <= 1'b1;
      end
      else if (accept)
      begin
         pkt_start <= i_beat.last;
      end
   end

   // gain taken with the header, used for the rest of the packet
   always_ff @(posedge clk)
   begin
      if (accept && pkt_start)
      begin
         pkt_gain <= i_gain;
      end
   end

   // output register
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_valid <= 1'b0;
      end
      else if (o_ready)
      begin
         o_valid <= i_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         o_beat.data <= out_word;
         o_beat.last <= i_beat.last;
      end
   end

endmodule

// File: stream_gain_top.sv
`timescale 1ns/10ps
// ------------------------------------------------
// stream gain subsystem
// input FIFO, complex gain stage and output FIFO
// on one valid/ready sample stream
// ------------------------------------------------
module stream_gain_top #(
   parameter int GAIN_FRAC_BITS = 14
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     i_clear,
   input  logic [15:0]              i_gain,
   // stream in
   input  stream_pkg::stream_beat_t i_beat,
   input  logic                     i_valid,
   output logic                     o_ready,
   // stream out
   output stream_pkg::stream_beat_t o_beat,
   output logic                     o_valid,
   input  logic                     i_ready,
   // diagnostics
   output logic [5:0]               o_in_space,
   output logic [5:0]               o_out_occupied
);
   import stream_pkg::*;

   localparam int BEAT_W = $bits(stream_beat_t);

   // input FIFO to gain stage
   stream_beat_t in_fifo_beat;
   logic         in_fifo_valid;
   logic         gain_ready;

   // gain stage to output FIFO
   stream_beat_t gain_beat;
   logic         gain_valid;
   logic         out_fifo_ready;

   // occupied count of the input FIFO not brought out
   axi_fifo_short #(
      .WIDTH (BEAT_W)
   ) u_in_fifo (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_tdata    (i_beat),
      .i_tvalid   (i_valid),
      .o_tready   (o_ready),
      .o_tdata    (in_fifo_beat),
      .o_tvalid   (in_fifo_valid),
      .i_tready   (gain_ready),
      .o_space    (o_in_space),
      .o_occupied ()
   );

   iq_gain_stage #(
      .GAIN_FRAC_BITS (GAIN_FRAC_BITS)
   ) u_gain (
      .clk     (clk),
      .reset   (reset),
      .i_clear (i_clear),
      .i_gain  (i_gain),
      .i_beat  (in_fifo_beat),
      .i_valid (in_fifo_valid),
      .o_ready (gain_ready),
      .o_beat  (gain_beat),
      .o_valid (gain_valid),
      .i_ready (out_fifo_ready)
   );

   // space count of the output FIFO not brought out
   axi_fifo_short #(
      .WIDTH (BEAT_W)
   ) u_out_fifo (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_tdata    (gain_beat),
      .i_tvalid   (gain_valid),
      .o_tready   (out_fifo_ready),
      .o_tdata    (o_beat),
      .o_tvalid   (o_valid),
      .i_tready   (i_ready),
      .o_space    (),
      .o_occupied (o_out_occupied)
   );

endmodule

// File: tb_stream_gain.sv
`timescale 1ns/10ps
// ------------------------------------------------
// stream gain testbench
// packets from a table pass through the subsystem
// and every output beat is checked against a model
// of the gain rule, with back-pressure and clear
// ------------------------------------------------
module tb_stream_gain;
   import stream_pkg::*;

   localparam int         GAIN_FRAC_BITS = 14;
   localparam int         NUM_TESTS      = 9;
   localparam logic [1:0] PAT_RAMP       = 2'd0;
   localparam logic [1:0] PAT_RAND       = 2'd1;
   localparam logic [1:0] PAT_FULL       = 2'd2;
   localparam logic [1:0] BP_NONE        = 2'd0;
   localparam logic [1:0] BP_RAND        = 2'd1;

   // one table row, the name lives in names[]
   typedef struct packed
   {
      logic [15:0] gain;
      logic [31:0] header;
      logic [15:0] count;
      logic [1:0]  pattern;
      logic [1:0]  bp;
      logic        clear;
   } test_t;

   // expected beat and the row it came from
   typedef struct packed
   {
      stream_beat_t beat;
      logic         hdr;
      logic [7:0]   test;
   } expect_t;

   logic         clk;
   logic         reset;
   logic         i_clear;
   logic [15:0]  i_gain;
   stream_beat_t i_beat;
   logic         i_valid;
   logic         o_ready;
   stream_beat_t o_beat;
   logic         o_valid;
   logic         i_ready;
   logic [5:0]   o_in_space;
   logic [5:0]   o_out_occupied;

   test_t      tests [NUM_TESTS];
   string      names [NUM_TESTS];
   expect_t    exp_q [$];
   int         errors = 0;
   int         checks = 0;
   int         cycle = 0;
   int         hdr_seen = -1;
   int         accept_cycle = 0;
   int         first_out_cycle = -1;
   int         gain_changes = 0;
   // written between edges, read by the ready driver on the edge
   logic [1:0] bp_mode = BP_NONE;
   bit         stall_hold = 1'b0;
   bit         clear_hold = 1'b0;
   bit         saw_stall = 1'b0;

   stream_gain_top #(
      .GAIN_FRAC_BITS (GAIN_FRAC_BITS)
   ) u_dut (
      .clk            (clk),
      .reset          (reset),
      .i_clear        (i_clear),
      .i_gain         (i_gain),
      .i_beat         (i_beat),
      .i_valid        (i_valid),
      .o_ready        (o_ready),
      .o_beat         (o_beat),
      .o_valid        (o_valid),
      .i_ready        (i_ready),
      .o_in_space     (o_in_space),
      .o_out_occupied (o_out_occupied)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      forever
      begin
         @(posedge clk);
         cycle++;
      end
   end

   // value times gain, plus half an lsb, arithmetic shift, clamp
   function automatic logic [15:0] model_scale(input logic [15:0] part, input logic [15:0] gain);
      longint scaled;
      scaled = longint'($signed(part)) * longint'(gain);
      scaled = (scaled + (longint'(1) << (GAIN_FRAC_BITS - 1))) >>> GAIN_FRAC_BITS;
      if (scaled > 32767)
      begin
         scaled = 32767;
      end
      else if (scaled < -32768)
      begin
         scaled = -32768;
      end
      return scaled[15:0];
   endfunction

   // sample k of a pattern, I in the upper half
   function automatic logic [31:0] sample_word(input logic [1:0] pattern, input int k);
      logic [15:0] re;
      logic [15:0] im;
      logic [31:0] r;
      case (pattern)
         PAT_RAMP:
         begin
            // odd steps crossing zero, so halves round both ways
            re = 16'(k * 411 - 3001);
            im = 16'(2501 - k * 377);
         end
         PAT_FULL:
         begin
            re = k[0] ? 16'h8000 : 16'h7fff;
            im = k[1] ? 16'h8000 : 16'h7fff;
         end
         default:
         begin
            r  = $urandom;
            re = r[31:16];
            im = r[15:0];
         end
      endcase
      return {re, im};
   endfunction

   function automatic int total_beats();
      int sum;
      sum = 0;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         sum += int'(tests[t].count) + 1;
      end
      return sum;
   endfunction

   task automatic fill_table();
      tests[0] = '{16'd16384, 32'h1001_0010, 16'd16, PAT_RAMP, BP_NONE, 1'b0};
      names[0] = "unity_ramp";
      tests[1] = '{16'd16384, 32'h1002_0014, 16'd20, PAT_RAND, BP_NONE, 1'b0};
      names[1] = "unity_random";
      tests[2] = '{16'd8192, 32'h2003_0018, 16'd24, PAT_RAMP, BP_NONE, 1'b0};
      names[2] = "half_gain";
      tests[3] = '{16'd24576, 32'h2004_0018, 16'd24, PAT_RAND, BP_NONE, 1'b0};
      names[3] = "gain_1p5";
      tests[4] = '{16'd65535, 32'h3005_000c, 16'd12, PAT_FULL, BP_NONE, 1'b0};
      names[4] = "saturate";
      tests[5] = '{16'd24576, 32'h4006_0050, 16'd80, PAT_RAND, BP_RAND, 1'b0};
      names[5] = "backpressure_long";
      tests[6] = '{16'd16384, 32'h5007_0028, 16'd40, PAT_RAMP, BP_NONE, 1'b1};
      names[6] = "clear_mid_packet";
      tests[7] = '{16'd8192, 32'h6008_0010, 16'd16, PAT_RAMP, BP_RAND, 1'b0};
      names[7] = "after_clear";
      tests[8] = '{16'd65535, 32'h7009_0020, 16'd32, PAT_FULL, BP_RAND, 1'b0};
      names[8] = "saturate_backpressure";
   endtask

   // called just after a rising edge, returns after the accepting edge
   task automatic send_beat(input stream_beat_t beat, output int acc_cycle);
      bit taken;
      i_beat  <= beat;
      i_valid <= 1'b1;
      taken = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken     = o_ready;
         acc_cycle = cycle;
         @(posedge clk);
      end
   endtask

   task automatic check_counters(input string label);
      checks += 2;
      if (o_in_space != 6'd32)
      begin
         errors++;
         $display("FAIL %s in_space expected %0d actual %0d", label, 32, o_in_space);
      end
      if (o_out_occupied != 6'd0)
      begin
         errors++;
         $display("FAIL %s out_occupied expected %0d actual %0d", label, 0, o_out_occupied);
      end
   endtask

   task automatic drain_output(input int idx);
      // the output hold ends once the whole packet is in
      @(negedge clk);
      stall_hold = 1'b0;
      while (exp_q.size() != 0)
      begin
         @(negedge clk);
      end
      // counters move on the edge that takes the last beat
      @(negedge clk);
      check_counters(names[idx]);
      if (tests[idx].bp == BP_RAND && tests[idx].count > 16'd64)
      begin
         checks++;
         if (!saw_stall)
         begin
            errors++;
            $display("%s: o_ready never dropped while the output was held", names[idx]);
         end
      end
   endtask

   task automatic apply_clear(input int idx);
      @(negedge clk);
      // stop the output first, so no beat moves across the clear
      clear_hold = 1'b1;
      @(posedge clk);
      i_clear <= 1'b1;
      @(posedge clk);
      i_clear <= 1'b0;
      @(negedge clk);
      checks++;
      if (o_valid !== 1'b0)
      begin
         errors++;
         $display("FAIL %s o_valid expected %b actual %b", names[idx], 1'b0, o_valid);
      end
      check_counters(names[idx]);
      // beats still in flight were dropped by the clear
      exp_q.delete();
      clear_hold = 1'b0;
   endtask

   task automatic run_packet(input int idx);
      test_t        t;
      stream_beat_t beat;
      expect_t      e;
      logic [31:0]  w;
      int           n;
      int           k;
      int           acc;
      bit           changed;
      t       = tests[idx];
      n       = t.clear ? int'(t.count) / 2 : int'(t.count);
      changed = 1'b0;
      @(negedge clk);
      bp_mode    = t.bp;
      // long packet: hold the output until the input side fills up
      stall_hold = (t.bp == BP_RAND) && (t.count > 16'd64);
      saw_stall  = 1'b0;
      @(posedge clk);
      i_gain <= t.gain;
      beat.data = t.header;
      beat.last = 1'b0;
      send_beat(beat, acc);
      if (idx == 0)
      begin
         accept_cycle = acc;
      end
      e.beat = beat;
      e.hdr  = 1'b1;
      e.test = 8'(idx);
      exp_q.push_back(e);
      for (k = 0; k < n; k++)
      begin
         // gain moves once the header is out, only the next packet may see it
         if (!changed && k >= n / 2 && hdr_seen == idx)
         begin
            i_gain <= t.gain ^ 16'h2aaa;
            changed = 1'b1;
            gain_changes++;
         end
         w         = sample_word(t.pattern, k);
         beat.data = w;
         beat.last = (k == n - 1) && !t.clear;
         send_beat(beat, acc);
         e.beat.data = {model_scale(w[31:16], t.gain), model_scale(w[15:0], t.gain)};
         e.beat.last = beat.last;
         e.hdr       = 1'b0;
         exp_q.push_back(e);
      end
      i_valid <= 1'b0;
      if (t.clear)
      begin
         apply_clear(idx);
      end
      else
      begin
         drain_output(idx);
      end
   endtask

   // output ready, random or held low
   initial
   begin
      logic [31:0] r;
      i_ready = 1'b1;
      forever
      begin
         @(posedge clk);
         r = $urandom;
         if (clear_hold || stall_hold)
         begin
            i_ready <= 1'b0;
         end
         else if (bp_mode == BP_RAND)
         begin
            i_ready <= r[0];
         end
         else
         begin
            i_ready <= 1'b1;
         end
      end
   end

   // output monitor, samples between edges
   initial
   begin
      expect_t e;
      forever
      begin
         @(negedge clk);
         if (stall_hold && !o_ready)
         begin
            saw_stall  = 1'b1;
            stall_hold = 1'b0;
         end
         if (o_valid && i_ready)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("output beat %h arrived when none was expected", o_beat);
            end
            else
            begin
               e = exp_q.pop_front();
               checks++;
               if (o_beat != e.beat)
               begin
                  errors++;
                  $display("FAIL %s expected %h actual %h", names[e.test], e.beat, o_beat);
               end
               if (e.hdr)
               begin
                  hdr_seen = int'(e.test);
               end
               if (e.test == 8'd0 && first_out_cycle < 0)
               begin
                  first_out_cycle = cycle;
               end
            end
         end
      end
   end

   // watchdog, 20 cycles per table beat plus reset and margin
   initial
   begin
      int limit;
      #1;
      limit = total_beats() * 20 + 16 + 200;
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles with %0d beats still expected", limit, exp_q.size());
      $display("Something failed");
      $finish;
   end

   initial
   begin
      void'($urandom(32'hb6aac2e5));
      reset   = 1'b1;
      i_clear = 1'b0;
      i_gain  = 16'd16384;
      i_beat  = '0;
      i_valid = 1'b0;
      fill_table();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_counters("after_reset");
      for (int idx = 0; idx < NUM_TESTS; idx++)
      begin
         run_packet(idx);
      end
      checks++;
      if (first_out_cycle - accept_cycle != 5)
      begin
         errors++;
         $display("FAIL %s latency expected %0d actual %0d", names[0], 5,
                  first_out_cycle - accept_cycle);
      end
      checks++;
      if (gain_changes == 0)
      begin
         errors++;
         $display("i_gain was never changed in the middle of a packet");
      end
      $display("errors %0d in %0d checks", errors, checks);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
stream_pkg.sv
srl_shift_store.sv
axi_fifo_short.sv
iq_gain_stage.sv
stream_gain_top.sv
tb_stream_gain.sv

// File: Makefile
# Verilator build and run of the stream gain testbench
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_stream_gain -f verilog.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
